/* tlc_defs.svh */
//******************************
// register map, command bits and timing constants of the
// timing and run-control core
// include wherever an address or a bit position is decoded
//******************************
`ifndef TLC_DEFS_SVH
`define TLC_DEFS_SVH

`default_nettype none

`define CYCLES_PER_MSEC 33 // 32.768 kHz cycles in one millisecond

// host register addresses
`define REG_COMMAND 7'h00
`define REG_STATUS 7'h01
`define REG_MS_PER_SAMPLE 7'h02
`define REG_INT_CTRL 7'h03
`define REG_INT_STAT 7'h04
`define REG_INT_FFE_MSG 7'h38

// command register bits
`define CMD_RUN_CONT 0 // run the FFE every sample period
`define CMD_RUN_ONCE 1 // single FFE run that clears itself
`define CMD_START_SM 2 // sensor manager start that clears itself
`define CMD_FAST_CLK 7

`define MS_PER_SAMPLE_RST 8'd1 // zero would mean no period at all
`define REG_UNMAPPED_VALUE 8'h21

`default_nettype wire

`endif

/* tlc_pkg.sv */
//******************************
// struct types shared between the control blocks
// and the testbench
//******************************
`default_nettype none

package tlc_pkg;

	// one host bus request sampled every clock
	typedef struct packed {
		logic [6:0] addr;
		logic [7:0] wdata;
		logic write; // 0 means read
	} regReqT;

	typedef struct packed {
		logic smBusy;
		logic ffeBusy;
	} busyT;

	// command bits that stay set after the write
	typedef struct packed {
		logic runContinuous;
		logic useFastClock;
	} cmdCtrlT;

	// strobes high for one clock after the command write
	typedef struct packed {
		logic runContWrite; // arms holdoff when run-continuous is written as 1
		logic runOnce;
		logic startSm;
	} cmdPulseT;

	typedef struct packed {
		logic enError; // bit 1
		logic enFfeMsg; // bit 0
	} intCtrlT;

	// status register listed msb first
	typedef struct packed {
		logic [2:0] reserved;
		logic i2cError;
		logic smOverrun;
		logic ffeOverrun;
		logic smBusy;
		logic ffeBusy;
	} statusT;

endpackage

`default_nettype wire

/* syncChain.sv */
//******************************
// register chain of any packed type cleared by reset
// serves as input synchronizer and as start delay line
// last two stages come out so the user can detect changes
//******************************
`timescale 1ns/1ps
`default_nettype none

module syncChain #(
	parameter type T = logic,
	parameter int Depth = 2 // 2 or more
) (
	input wire Clock32KIn,
	input wire ResetIn,
	input wire T d_i,
	output T last_o,
	output T prev_o
);

	T stage [Depth]; // stage[0] samples d_i

	always_ff @(posedge Clock32KIn or posedge ResetIn) begin
		if (ResetIn) begin
			for (int i = 0; i < Depth; i++) begin
				stage[i] <= '0;
			end
		end else begin
			stage[0] <= d_i;
			for (int i = 1; i < Depth; i++) begin
				stage[i] <= stage[i-1]; // shift one per clock
			end
		end
	end

	assign last_o = stage[Depth-1];
	assign prev_o = stage[Depth-2];

endmodule

`default_nettype wire

/* sampleTimer.sv */
//******************************
// millisecond timestamp and sample period timer
// issues periodic FFE runs as a toggle when run-continuous is set,
// records an overrun when a period ends with the FFE still busy
//******************************
`timescale 1ns/1ps
`include "tlc_defs.svh"
`default_nettype none

module sampleTimer (
	input wire Clock32KIn,
	input wire ResetIn,
	input wire tlc_pkg::cmdCtrlT cmdCtrl_i,
	input wire runContWrite_i,
	input wire [7:0] msPerSample_i,
	input wire ffeBusy_i,
	output logic [15:0] timeStamp_o,
	output logic timeStampTog_o,
	output logic ffeRunToggle_o,
	output logic ffeOverrun_o
);

	localparam int CycW = $clog2(`CYCLES_PER_MSEC);

	logic [CycW-1:0] cycCnt; // 32k cycles within the current ms
	logic [7:0] msecCnt; // ms left in the sample period
	logic holdoff; // first continuous run waits a full period
	logic pulse1ms;
	logic samplePulse;
	logic periodicRun;

	assign pulse1ms = (cycCnt == CycW'(`CYCLES_PER_MSEC - 1));
	assign samplePulse = pulse1ms && (msecCnt == 8'd1); // last ms of the period
	assign periodicRun = samplePulse && cmdCtrl_i.runContinuous && !holdoff;

	always_ff @(posedge Clock32KIn or posedge ResetIn) begin
		if (ResetIn) begin
			cycCnt <= '0;
			msecCnt <= 8'd1;
			timeStamp_o <= '0;
			timeStampTog_o <= 1'b0;
			holdoff <= 1'b0;
			ffeRunToggle_o <= 1'b0;
			ffeOverrun_o <= 1'b0;
		end else begin
			if (pulse1ms) begin
				cycCnt <= '0;
				timeStamp_o <= timeStamp_o + 16'd1;
				timeStampTog_o <= ~timeStampTog_o; // lets a slower domain see each tick
			end else begin
				cycCnt <= cycCnt + 1'b1;
			end

			if (samplePulse)
				msecCnt <= msPerSample_i; // reload at the period boundary
			else if (pulse1ms)
				msecCnt <= msecCnt - 8'd1;

			// arming wins over the clear from a boundary in the same clock
			if (runContWrite_i)
				holdoff <= 1'b1;
			else if (samplePulse)
				holdoff <= 1'b0;

			if (periodicRun) begin
				if (ffeBusy_i)
					ffeOverrun_o <= 1'b1; // sticky until reset
				else
					ffeRunToggle_o <= ~ffeRunToggle_o;
			end
		end
	end

endmodule

`default_nettype wire

/* runSequencer.sv */
//******************************
// FFE and SM start sequencing
// merges once and periodic runs, delays the start toggles and
// gates the FFE and shared clock enables from the synced busy lines
//******************************
`timescale 1ns/1ps
`default_nettype none

module runSequencer (
	input wire Clock32KIn,
	input wire ResetIn,
	input wire ffeRunToggle_i,
	input wire runOnce_i,
	input wire startSm_i,
	input wire tlc_pkg::busyT busy_i,
	output logic startFfe_o,
	output logic startSm_o,
	output logic ffeClkEn_o,
	output logic clockEnable_o
);

	import tlc_pkg::*;

	logic onceTog; // flips per run-once command
	logic ffeReqTog;
	logic ffeReqS1; // first stage of the FFE start delay
	logic smTog;
	logic [2:0] smKick; // SM strobe lined up with stage 2/3 of the SM delay
	busyT busyS2;
	busyT busyS3;
	logic anyBusyS2;
	logic anyBusyS3;
	logic ffeClkRise;
	logic ffeClkFall;

	assign ffeReqTog = ffeRunToggle_i ^ onceTog; // any flip is a new request

	syncChain #(.T(logic), .Depth(2)) uFfeStart (
		.Clock32KIn(Clock32KIn),
		.ResetIn(ResetIn),
		.d_i(ffeReqTog),
		.last_o(startFfe_o),
		.prev_o(ffeReqS1)
	);

	syncChain #(.T(busyT), .Depth(3)) uBusySync (
		.Clock32KIn(Clock32KIn),
		.ResetIn(ResetIn),
		.d_i(busy_i),
		.last_o(busyS3),
		.prev_o(busyS2)
	);

	// SM side sees the start late so the shared clock has time to come up
	syncChain #(.T(logic), .Depth(6)) uSmStart (
		.Clock32KIn(Clock32KIn),
		.ResetIn(ResetIn),
		.d_i(smTog),
		.last_o(startSm_o),
		.prev_o()
	);

	assign ffeClkRise = !ffeClkEn_o && (ffeReqS1 ^ ffeReqTog); // new request not yet delayed
	assign ffeClkFall = ffeClkEn_o && busyS3.ffeBusy && !busyS2.ffeBusy; // busy end
	assign anyBusyS2 = busyS2.ffeBusy | busyS2.smBusy;
	assign anyBusyS3 = busyS3.ffeBusy | busyS3.smBusy;

	always_ff @(posedge Clock32KIn or posedge ResetIn) begin
		if (ResetIn) begin
			onceTog <= 1'b0;
			smTog <= 1'b0;
			smKick <= '0;
			ffeClkEn_o <= 1'b0;
			clockEnable_o <= 1'b0;
		end else begin
			onceTog <= onceTog ^ runOnce_i;
			smTog <= smTog ^ startSm_i;
			smKick <= {smKick[1:0], startSm_i};

			if (ffeClkRise)
				ffeClkEn_o <= 1'b1;
			else if (ffeClkFall)
				ffeClkEn_o <= 1'b0;

			// shared clock stays on until both engines went idle
			if (clockEnable_o) begin
				if (!anyBusyS2 && anyBusyS3)
					clockEnable_o <= 1'b0;
			end else if (ffeClkRise || smKick[2]) begin
				clockEnable_o <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* interruptCtrl.sv */
//******************************
// interrupt latches and the level interrupt pin
// FFE messages clear per bit from the host and the I2C error sticks
//******************************
`timescale 1ns/1ps
`default_nettype none

module interruptCtrl (
	input wire Clock32KIn,
	input wire ResetIn,
	input wire [7:0] ffeMsg_i,
	input wire [7:0] msgClear_i,
	input wire i2cError_i,
	input wire smOverrun_i,
	input wire ffeOverrun_i,
	input wire tlc_pkg::intCtrlT intCtrl_i,
	output logic [7:0] msgLatched_o,
	output logic i2cErrorLatched_o,
	output logic interrupt_o
);

	logic anyMsg;
	logic anyError;

	always_ff @(posedge Clock32KIn or posedge ResetIn) begin
		if (ResetIn) begin
			msgLatched_o <= '0;
			i2cErrorLatched_o <= 1'b0;
		end else begin
			msgLatched_o <= (msgLatched_o & ~msgClear_i) | ffeMsg_i; // new message beats clear
			i2cErrorLatched_o <= i2cErrorLatched_o | i2cError_i;
		end
	end

	assign anyMsg = |msgLatched_o;
	assign anyError = i2cErrorLatched_o || smOverrun_i || ffeOverrun_i;

	// active high level held until the source is cleared
	assign interrupt_o = (intCtrl_i.enFfeMsg && anyMsg) ||
		(intCtrl_i.enError && anyError);

endmodule

`default_nettype wire

/* hostRegs.sv */
//******************************
// host register file on the strobe bus
// write in any clock with write set and read data one clock later
// command bits become held levels or one-clock strobes
//******************************
`timescale 1ns/1ps
`include "tlc_defs.svh"
`default_nettype none

module hostRegs (
	input wire Clock32KIn,
	input wire ResetIn,
	input wire tlc_pkg::regReqT regReq_i,
	input wire tlc_pkg::busyT busy_i,
	input wire smOverrun_i,
	input wire ffeOverrun_i,
	input wire i2cError_i,
	input wire [7:0] msgLatched_i,
	output logic [7:0] regData_o,
	output tlc_pkg::cmdCtrlT cmdCtrl_o,
	output tlc_pkg::cmdPulseT cmdPulse_o,
	output logic [7:0] msPerSample_o,
	output tlc_pkg::intCtrlT intCtrl_o,
	output logic [7:0] msgClear_o,
	output logic useFastClock_o
);

	import tlc_pkg::*;

	logic cmdWrite;
	logic [7:0] cmdRead;
	statusT status;

	assign cmdWrite = regReq_i.write && (regReq_i.addr == `REG_COMMAND);
	assign useFastClock_o = cmdCtrl_o.useFastClock;

	// self clearing bits read back as 0
	always_comb begin
		cmdRead = '0;
		cmdRead[`CMD_RUN_CONT] = cmdCtrl_o.runContinuous;
		cmdRead[`CMD_FAST_CLK] = cmdCtrl_o.useFastClock;
	end

	always_comb begin
		status = '0;
		status.ffeBusy = busy_i.ffeBusy; // raw input without syncing
		status.smBusy = busy_i.smBusy;
		status.ffeOverrun = ffeOverrun_i;
		status.smOverrun = smOverrun_i;
		status.i2cError = i2cError_i;
	end

	always_ff @(posedge Clock32KIn or posedge ResetIn) begin
		if (ResetIn) begin
			regData_o <= '0;
			cmdCtrl_o <= '0;
			cmdPulse_o <= '0;
			msPerSample_o <= `MS_PER_SAMPLE_RST;
			intCtrl_o <= '0;
			msgClear_o <= '0;
		end else begin
			// strobes last exactly one clock
			cmdPulse_o.runContWrite <= cmdWrite && regReq_i.wdata[`CMD_RUN_CONT];
			cmdPulse_o.runOnce <= cmdWrite && regReq_i.wdata[`CMD_RUN_ONCE];
			cmdPulse_o.startSm <= cmdWrite && regReq_i.wdata[`CMD_START_SM];
			msgClear_o <= '0;

			if (regReq_i.write) begin
				case (regReq_i.addr)
					`REG_COMMAND: begin
						cmdCtrl_o.runContinuous <= regReq_i.wdata[`CMD_RUN_CONT];
						cmdCtrl_o.useFastClock <= regReq_i.wdata[`CMD_FAST_CLK];
					end
					`REG_MS_PER_SAMPLE: msPerSample_o <= regReq_i.wdata;
					`REG_INT_CTRL: intCtrl_o <= intCtrlT'(regReq_i.wdata[1:0]);
					`REG_INT_FFE_MSG: msgClear_o <= regReq_i.wdata; // write 1 to clear
					default: ;
				endcase
			end else begin
				case (regReq_i.addr)
					`REG_COMMAND: regData_o <= cmdRead;
					`REG_STATUS: regData_o <= status;
					`REG_MS_PER_SAMPLE: regData_o <= msPerSample_o;
					`REG_INT_CTRL: regData_o <= {6'b0, intCtrl_o};
					`REG_INT_STAT: regData_o <= {7'b0, |msgLatched_i};
					`REG_INT_FFE_MSG: regData_o <= msgLatched_i;
					default: regData_o <= `REG_UNMAPPED_VALUE;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

/* tlcTop.sv */
//******************************
// timing and run-control top level
// host registers, sample timer, run sequencer and interrupts
// all on the 32 kHz clock
//******************************
`timescale 1ns/1ps
`default_nettype none

module tlcTop (
	input wire Clock32KIn,
	input wire ResetIn,
	input wire tlc_pkg::regReqT regReq_i,
	output logic [7:0] regData_o,
	input wire tlc_pkg::busyT busy_i,
	input wire smOverrun_i,
	input wire i2cError_i,
	input wire [7:0] ffeMsg_i,
	output logic startFfe_o,
	output logic startSm_o,
	output logic ffeClkEn_o,
	output logic clockEnable_o,
	output logic [15:0] timeStamp_o,
	output logic timeStampTog_o,
	output logic interrupt_o,
	output logic useFastClock_o
);

	import tlc_pkg::*;

	cmdCtrlT cmdCtrl;
	cmdPulseT cmdPulse;
	intCtrlT intCtrl;
	logic [7:0] msPerSample;
	logic [7:0] msgClear;
	logic [7:0] msgLatched;
	logic i2cErrorLatched;
	logic ffeRunToggle; // periodic run request
	logic ffeOverrun;

	hostRegs uHostRegs (
		.Clock32KIn(Clock32KIn),
		.ResetIn(ResetIn),
		.regReq_i(regReq_i),
		.busy_i(busy_i),
		.smOverrun_i(smOverrun_i),
		.ffeOverrun_i(ffeOverrun),
		.i2cError_i(i2cErrorLatched),
		.msgLatched_i(msgLatched),
		.regData_o(regData_o),
		.cmdCtrl_o(cmdCtrl),
		.cmdPulse_o(cmdPulse),
		.msPerSample_o(msPerSample),
		.intCtrl_o(intCtrl),
		.msgClear_o(msgClear),
		.useFastClock_o(useFastClock_o)
	);

	sampleTimer uSampleTimer (
		.Clock32KIn(Clock32KIn),
		.ResetIn(ResetIn),
		.cmdCtrl_i(cmdCtrl),
		.runContWrite_i(cmdPulse.runContWrite),
		.msPerSample_i(msPerSample),
		.ffeBusy_i(busy_i.ffeBusy),
		.timeStamp_o(timeStamp_o),
		.timeStampTog_o(timeStampTog_o),
		.ffeRunToggle_o(ffeRunToggle),
		.ffeOverrun_o(ffeOverrun)
	);

	runSequencer uRunSeq (
		.Clock32KIn(Clock32KIn),
		.ResetIn(ResetIn),
		.ffeRunToggle_i(ffeRunToggle),
		.runOnce_i(cmdPulse.runOnce),
		.startSm_i(cmdPulse.startSm),
		.busy_i(busy_i),
		.startFfe_o(startFfe_o),
		.startSm_o(startSm_o),
		.ffeClkEn_o(ffeClkEn_o),
		.clockEnable_o(clockEnable_o)
	);

	interruptCtrl uIntCtrl (
		.Clock32KIn(Clock32KIn),
		.ResetIn(ResetIn),
		.ffeMsg_i(ffeMsg_i),
		.msgClear_i(msgClear),
		.i2cError_i(i2cError_i),
		.smOverrun_i(smOverrun_i),
		.ffeOverrun_i(ffeOverrun),
		.intCtrl_i(intCtrl),
		.msgLatched_o(msgLatched),
		.i2cErrorLatched_o(i2cErrorLatched),
		.interrupt_o(interrupt_o)
	);

endmodule

`default_nettype wire

/* tlc_properties.sv */
//******************************
// concurrent checks on the run-control top level
// start delay, interrupt masking and the sticky overrun flag
// bound into tlcTop from the testbench
//******************************
`timescale 1ns/1ps
`default_nettype none

module tlcProperties (
	input wire Clock32KIn,
	input wire ResetIn,
	input wire ffeReqTog_i, // merged once/periodic request inside the sequencer
	input wire startFfe_i,
	input wire tlc_pkg::intCtrlT intCtrl_i,
	input wire interrupt_i,
	input wire ffeOverrun_i
);

	int failCount = 0; // checks failed so far

	// start toggle is the request toggle seen through two registers
	startDelay: assert property (@(posedge Clock32KIn) disable iff (ResetIn)
		$changed(startFfe_i) |-> ($past(ffeReqTog_i, 2) != $past(ffeReqTog_i, 3)))
	else begin
		failCount++;
		$error("startFfe_o changed without a request toggle two cycles before");
	end

	// no enable, no pin
	intMasked: assert property (@(posedge Clock32KIn) disable iff (ResetIn)
		(!intCtrl_i.enFfeMsg && !intCtrl_i.enError) |-> !interrupt_i)
	else begin
		failCount++;
		$error("interrupt_o high with both interrupt enables clear");
	end

	overrunSticky: assert property (@(posedge Clock32KIn) disable iff (ResetIn)
		ffeOverrun_i |=> ffeOverrun_i) // only reset clears it
	else begin
		failCount++;
		$error("FFE overrun flag dropped without reset");
	end

endmodule

`default_nettype wire

/* tlc_tb.sv */
//******************************
// directed testbench for the timing and run-control top level
// one task per feature with the bus driven on falling edges
// the run stops at the first wrong value
//******************************
`timescale 1ns/1ps
`include "tlc_defs.svh"
`default_nettype none

module tlc_tb;

	import tlc_pkg::*;

	localparam int TimeoutCycles = 6000; // several times the length of all tests together
	localparam int MsecCycles = `CYCLES_PER_MSEC;

	logic Clock32KIn;
	logic ResetIn;
	regReqT regReq;
	busyT busy;
	logic smOverrun;
	logic i2cError;
	logic [7:0] ffeMsg;
	logic [7:0] regData;
	logic startFfe;
	logic startSm;
	logic ffeClkEn;
	logic clockEnable;
	logic [15:0] timeStamp;
	logic timeStampTog;
	logic interrupt;
	logic useFastClock;
	int cycleCount = 0;
	int unsigned seedState;

	tlcTop uut (
		.Clock32KIn(Clock32KIn),
		.ResetIn(ResetIn),
		.regReq_i(regReq),
		.regData_o(regData),
		.busy_i(busy),
		.smOverrun_i(smOverrun),
		.i2cError_i(i2cError),
		.ffeMsg_i(ffeMsg),
		.startFfe_o(startFfe),
		.startSm_o(startSm),
		.ffeClkEn_o(ffeClkEn),
		.clockEnable_o(clockEnable),
		.timeStamp_o(timeStamp),
		.timeStampTog_o(timeStampTog),
		.interrupt_o(interrupt),
		.useFastClock_o(useFastClock)
	);

	bind tlcTop tlcProperties uProps (
		.Clock32KIn(Clock32KIn),
		.ResetIn(ResetIn),
		.ffeReqTog_i(uRunSeq.ffeReqTog),
		.startFfe_i(startFfe_o),
		.intCtrl_i(intCtrl),
		.interrupt_i(interrupt_o),
		.ffeOverrun_i(ffeOverrun)
	);

	initial begin
		Clock32KIn = 1'b0;
		forever #10 Clock32KIn = ~Clock32KIn; // 20 ns period
	end

	always @(posedge Clock32KIn) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= TimeoutCycles)
			abortRun($sformatf("timeout, run did not finish within %0d cycles", TimeoutCycles));
	end

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic expectEq(input string name, input logic [15:0] got, input logic [15:0] exp);
		assert (got === exp) else
			abortRun($sformatf("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	// reset held for two clocks and released on a falling edge
	task automatic applyReset();
		ResetIn = 1'b1;
		regReq = '0;
		busy = '0;
		ffeMsg = '0;
		i2cError = 1'b0;
		repeat (2) @(posedge Clock32KIn);
		@(negedge Clock32KIn);
		ResetIn = 1'b0;
	endtask

	// returns on the falling edge right after the write edge
	task automatic regWrite(input logic [6:0] addr, input logic [7:0] data);
		@(negedge Clock32KIn);
		regReq.addr = addr;
		regReq.wdata = data;
		regReq.write = 1'b1;
		@(negedge Clock32KIn);
		regReq.write = 1'b0;
	endtask

	task automatic regRead(input logic [6:0] addr, input logic [7:0] exp, input string name);
		@(negedge Clock32KIn);
		regReq.addr = addr;
		regReq.write = 1'b0;
		@(negedge Clock32KIn); // one cycle read latency
		expectEq(name, regData, exp);
	endtask

	task automatic resetReadback();
		logic [7:0] msVal;
		logic [7:0] intVal;
		applyReset();
		expectEq("startFfe_o", startFfe, 0);
		expectEq("startSm_o", startSm, 0);
		expectEq("ffeClkEn_o", ffeClkEn, 0);
		expectEq("clockEnable_o", clockEnable, 0);
		expectEq("interrupt_o", interrupt, 0);
		expectEq("useFastClock_o", useFastClock, 0);
		expectEq("timeStamp_o", timeStamp, 0);
		regRead(`REG_COMMAND, 8'h00, "command");
		regRead(`REG_STATUS, 8'h00, "status");
		regRead(`REG_MS_PER_SAMPLE, 8'h01, "ms per sample");
		regRead(`REG_INT_CTRL, 8'h00, "interrupt control");
		regRead(`REG_INT_STAT, 8'h00, "interrupt status");
		regRead(`REG_INT_FFE_MSG, 8'h00, "ffe messages");
		msVal = $urandom;
		intVal = $urandom;
		regWrite(`REG_MS_PER_SAMPLE, msVal);
		regRead(`REG_MS_PER_SAMPLE, msVal, "ms per sample");
		regWrite(`REG_INT_CTRL, intVal);
		regRead(`REG_INT_CTRL, intVal & 8'h03, "interrupt control"); // two enable bits only
		regRead(7'h55, 8'h21, "unmapped address");
		regWrite(`REG_COMMAND, 8'h80);
		expectEq("useFastClock_o", useFastClock, 1);
		regRead(`REG_COMMAND, 8'h80, "command");
	endtask

	task automatic timestampTicks();
		logic [15:0] lastStamp;
		logic lastTog;
		int gap;
		int tick;
		applyReset();
		lastStamp = timeStamp;
		gap = 0;
		while (timeStamp == lastStamp && gap <= MsecCycles + 5) begin
			@(negedge Clock32KIn);
			gap++;
		end
		assert (timeStamp != lastStamp) else abortRun("timestamp never advanced after reset");
		for (tick = 0; tick < 3; tick++) begin
			lastStamp = timeStamp;
			lastTog = timeStampTog;
			gap = 0;
			while (timeStamp == lastStamp && gap <= MsecCycles + 5) begin
				@(negedge Clock32KIn);
				gap++;
			end
			expectEq("cycles per timestamp tick", gap, MsecCycles);
			expectEq("timeStamp_o", timeStamp, lastStamp + 16'd1);
			expectEq("timeStampTog_o", timeStampTog, !lastTog);
		end
	endtask

	task automatic runOnceStart();
		logic prevStart;
		int n;
		applyReset();
		prevStart = startFfe;
		regWrite(`REG_COMMAND, 8'h01 << `CMD_RUN_ONCE);
		n = 0;
		while (startFfe == prevStart && n < 5) begin
			@(negedge Clock32KIn);
			n++;
		end
		assert (startFfe != prevStart) else
			abortRun("startFfe_o did not toggle after a run-once write");
		expectEq("ffeClkEn_o", ffeClkEn, 1);
		expectEq("clockEnable_o", clockEnable, 1);
		busy.ffeBusy = 1'b1;
		repeat (4) @(negedge Clock32KIn);
		expectEq("ffeClkEn_o", ffeClkEn, 1); // held while the FFE works
		busy.ffeBusy = 1'b0;
		n = 0;
		while (ffeClkEn && n < 5) begin
			@(negedge Clock32KIn);
			n++;
		end
		assert (!ffeClkEn) else abortRun("ffeClkEn_o did not fall after ffeBusy dropped");
		n = 0;
		while (clockEnable && n < 5) begin
			@(negedge Clock32KIn);
			n++;
		end
		assert (!clockEnable) else
			abortRun("clockEnable_o did not fall after the busy lines dropped");
	endtask

	task automatic continuousOverrun();
		logic prevStart;
		int n;
		applyReset();
		regWrite(`REG_MS_PER_SAMPLE, 8'd2);
		prevStart = startFfe;
		regWrite(`REG_COMMAND, 8'h01 << `CMD_RUN_CONT);
		for (n = 0; n < 2 * MsecCycles; n++) begin
			@(negedge Clock32KIn);
			assert (startFfe == prevStart) else
				abortRun("startFfe_o toggled during the holdoff");
		end
		n = 0;
		while (startFfe == prevStart && n < 4 * MsecCycles) begin
			@(negedge Clock32KIn);
			n++;
		end
		assert (startFfe != prevStart) else abortRun("no periodic FFE start after the holdoff");
		prevStart = startFfe;
		n = 0;
		while (startFfe == prevStart && n < 4 * MsecCycles) begin
			@(negedge Clock32KIn);
			n++;
		end
		expectEq("cycles between periodic starts", n, 2 * MsecCycles);
		// FFE still busy when the next period ends
		busy.ffeBusy = 1'b1;
		prevStart = startFfe;
		for (n = 0; n < 80; n++) begin
			@(negedge Clock32KIn);
			assert (startFfe == prevStart) else abortRun("periodic start issued while FFE busy");
		end
		busy.ffeBusy = 1'b0;
		regRead(`REG_STATUS, 8'h04, "status after overrun");
		expectEq("interrupt_o", interrupt, 0);
		regWrite(`REG_INT_CTRL, 8'h02); // error enable only
		expectEq("interrupt_o", interrupt, 1);
		regWrite(`REG_COMMAND, 8'h00);
	endtask

	task automatic msgInterrupts();
		logic [7:0] mask;
		applyReset();
		mask = 8'h01 << ($urandom % 8);
		@(negedge Clock32KIn);
		ffeMsg = mask; // single-cycle message pulse
		@(negedge Clock32KIn);
		ffeMsg = '0;
		regRead(`REG_INT_FFE_MSG, mask, "ffe messages");
		regRead(`REG_INT_STAT, 8'h01, "interrupt status");
		expectEq("interrupt_o", interrupt, 0);
		regWrite(`REG_INT_CTRL, 8'h01);
		expectEq("interrupt_o", interrupt, 1);
		regWrite(`REG_INT_FFE_MSG, mask);
		regRead(`REG_INT_FFE_MSG, 8'h00, "ffe messages after clear");
		regRead(`REG_INT_STAT, 8'h00, "interrupt status after clear");
		expectEq("interrupt_o", interrupt, 0);
		@(negedge Clock32KIn);
		i2cError = 1'b1;
		@(negedge Clock32KIn);
		i2cError = 1'b0;
		regRead(`REG_STATUS, 8'h10, "status with i2c error");
		repeat (10) @(negedge Clock32KIn);
		regRead(`REG_STATUS, 8'h10, "status with i2c error"); // sticky
	endtask

	task automatic smStartDelay();
		logic prevSm;
		int n;
		applyReset();
		prevSm = startSm;
		regWrite(`REG_COMMAND, 8'h01 << `CMD_START_SM);
		for (n = 1; n <= 7; n++) begin
			@(negedge Clock32KIn); // now n edges past the write edge
			expectEq($sformatf("startSm_o %0d cycles after write", n), startSm,
				(n == 7) ? !prevSm : prevSm);
		end
		expectEq("clockEnable_o", clockEnable, 1);
	endtask

	initial begin
		ResetIn = 1'b1;
		regReq = '0;
		busy = '0;
		smOverrun = 1'b0;
		i2cError = 1'b0;
		ffeMsg = '0;
		seedState = $urandom(32'h56b2_38e0);
		resetReadback();
		timestampTicks();
		runOnceStart();
		continuousOverrun();
		msgInterrupts();
		smStartDelay();
		repeat (2) @(negedge Clock32KIn);
		if (uut.uProps.failCount != 0) begin
			abortRun("concurrent assertions failed during the run");
		end else begin
			$display("Simulation passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+.
tlc_pkg.sv
syncChain.sv
sampleTimer.sv
runSequencer.sv
interruptCtrl.sv
hostRegs.sv
tlcTop.sv
tlc_properties.sv
tlc_tb.sv
